// ==== scc_wave.f ====
+incdir+design
+incdir+tb
design/scc_pkg.sv
design/scc_register.sv
design/scc_selector.sv
design/scc_wave_memory.sv
design/scc_tone_generator.sv
design/scc_wave.sv
tb/tb_scc_wave.sv

// ==== tb/tb_scc_wave_cases.svh ====
// Case table of the wave-table core testbench
// Columns: name, operation, address, data, expected value
// Only map and select probes take the expected column, reads and samples use the model

`ifndef TB_SCC_WAVE_CASES_SVH
`define TB_SCC_WAVE_CASES_SVH

task automatic load_cases();
	// Reset state
	add_case("reset_bank0", OP_MAP, 15'h4000, 8'h00, 'h00);
	add_case("reset_bank1", OP_MAP, 15'h6000, 8'h00, 'h01);
	add_case("reset_bank2", OP_MAP, 15'h0000, 8'h00, 'h02);
	add_case("reset_bank3", OP_MAP, 15'h2000, 8'h00, 'h03);
	add_case("reset_select", OP_NACTIVE, 15'h0000, 8'h00, 1);
	add_case("reset_sample", OP_SAMPLE, 15'h0000, 8'h00, 0);
	// Mapper banks and RAM mode
	add_case("bank0_write", OP_WRITE, 15'h5000, 8'h12, 0);
	add_case("bank0_map", OP_MAP, 15'h4000, 8'h00, 'h12);
	add_case("bank3_write", OP_WRITE, 15'h3000, 8'h80, 0);
	add_case("bank3_map", OP_MAP, 15'h2000, 8'h00, 'h80);
	add_case("mode_ram_bank0", OP_WRITE, 15'h3FFE, 8'h01, 0);
	add_case("bank0_locked", OP_WRITE, 15'h5000, 8'h34, 0);
	add_case("bank0_kept", OP_MAP, 15'h4000, 8'h00, 'h12);
	add_case("mode_clear", OP_WRITE, 15'h3FFF, 8'h00, 0);
	add_case("bank2_write", OP_WRITE, 15'h1000, 8'h3F, 0);
	add_case("bank2_map", OP_MAP, 15'h0000, 8'h00, 'h3F);
	// SCC window, tables A to D
	add_case("scc_fill_a0", OP_FILL, 15'h1800, 8'h00, 0);
	add_case("scc_fill_a31", OP_FILL, 15'h181F, 8'h00, 0);
	add_case("scc_fill_b0", OP_FILL, 15'h1820, 8'h00, 0);
	add_case("scc_fill_c0", OP_FILL, 15'h1840, 8'h00, 0);
	add_case("scc_fill_d0", OP_FILL, 15'h1860, 8'h00, 0);
	add_case("scc_fill_d5", OP_FILL, 15'h1865, 8'h00, 0);
	add_case("scc_read_a0", OP_READ, 15'h1800, 8'h00, 0);
	add_case("scc_read_a31", OP_READ, 15'h181F, 8'h00, 0);
	add_case("scc_read_b0", OP_READ, 15'h1820, 8'h00, 0);
	add_case("scc_read_c0", OP_READ, 15'h1840, 8'h00, 0);
	add_case("scc_read_d0", OP_READ, 15'h1860, 8'h00, 0);
	add_case("scc_read_d5", OP_READ, 15'h1865, 8'h00, 0);
	add_case("scc_read_only_0", OP_READ, 15'h18A0, 8'h00, 0);
	add_case("scc_read_only_5", OP_READ, 15'h18A5, 8'h00, 0);
	// SCCI window, table E
	add_case("mode_scci", OP_WRITE, 15'h3FFE, 8'h20, 0);
	add_case("scci_fill_e0", OP_FILL, 15'h3880, 8'h00, 0);
	add_case("scci_fill_e17", OP_FILL, 15'h3891, 8'h00, 0);
	add_case("scci_read_e0", OP_READ, 15'h3880, 8'h00, 0);
	add_case("scci_read_e17", OP_READ, 15'h3891, 8'h00, 0);
	add_case("scci_read_a0", OP_READ, 15'h3800, 8'h00, 0);
	add_case("scc_window_closed", OP_NO_READ, 15'h1800, 8'h00, 0);
	// Mixing with every pointer held at index 0
	add_case("wave_reset_on", OP_WRITE, 15'h38C0, 8'h20, 0);
	add_case("freq_a_low", OP_WRITE, 15'h38A0, 8'h10, 0);
	add_case("volume_a", OP_WRITE, 15'h38AA, 8'h0F, 0);
	add_case("volume_b", OP_WRITE, 15'h38AB, 8'h08, 0);
	add_case("volume_c", OP_WRITE, 15'h38AC, 8'h03, 0);
	add_case("volume_d", OP_WRITE, 15'h38AD, 8'h0C, 0);
	add_case("volume_e", OP_WRITE, 15'h38AE, 8'h0A, 0);
	add_case("mask_abde", OP_WRITE, 15'h38AF, 8'h1B, 0);
	add_case("mix_abde", OP_SAMPLE, 15'h0000, 8'h00, 0);
	add_case("mask_all", OP_WRITE, 15'h38AF, 8'h1F, 0);
	add_case("mix_all", OP_SAMPLE, 15'h0000, 8'h00, 0);
	// Writes while the core is disabled
	add_case("disable", OP_ENABLE, 15'h0000, 8'h00, 0);
	add_case("off_bank3", OP_WRITE, 15'h3000, 8'h05, 0);
	add_case("off_table_e", OP_WRITE, 15'h3880, 8'hAA, 0);
	add_case("off_mask", OP_WRITE, 15'h38AF, 8'h00, 0);
	add_case("reenable", OP_ENABLE, 15'h0000, 8'h01, 0);
	add_case("off_bank3_kept", OP_MAP, 15'h2000, 8'h00, 'h80);
	add_case("off_table_e_kept", OP_READ, 15'h3880, 8'h00, 0);
	add_case("off_mask_kept", OP_SAMPLE, 15'h0000, 8'h00, 0);
endtask

`endif

// ==== tb/tb_scc_wave.sv ====
// Testbench of the wave-table core
// Runs the case table in order, a reference model gives read and sample values
// Wave bytes are random from a fixed seed, mixing checks assume wave reset is set

`timescale 1ns/1ns
`default_nettype none

`include "scc_defines.svh"

module tb_scc_wave;
	import scc_pkg::*;

	localparam int READ_LATENCY = 3;
	localparam int READ_TIMEOUT = 8;
	localparam int SAMPLE_TIMEOUT = 20;

	typedef enum int {
		OP_WRITE, OP_FILL, OP_READ, OP_NO_READ, OP_MAP, OP_NACTIVE, OP_SAMPLE, OP_ENABLE
	} op_t;

	typedef struct {
		string       name;
		op_t         op;
		logic [14:0] addr;
		logic [7:0]  data;
		int          expected;
	} case_t;

	logic                             clk;
	logic                             nreset;
	logic                             enable;
	scc_bus_t                         bus;
	logic [7:0]                       rddata;
	logic                             rddata_en;
	logic                             ext_memory_nactive;
	logic [7:0]                       ext_memory_address;
	logic signed [`SCC_SAMPLE_W-1:0]  sample;
	logic                             sample_valid;

	case_t cases [$];
	int    check_errors;
	int    tests_ok;
	int    tests_bad;

	// Reference model state
	logic [7:0] bank_model [4];
	logic [3:0] ram_model;
	logic       scci_model;
	logic [7:0] wave_model [`SCC_CHANNELS][`SCC_WAVE_DEPTH];
	logic [3:0] vol_model [`SCC_CHANNELS];
	logic [4:0] mask_model;

	scc_wave i_scc_wave (
		.clk                (clk),
		.nreset             (nreset),
		.enable             (enable),
		.bus                (bus),
		.rddata             (rddata),
		.rddata_en          (rddata_en),
		.ext_memory_nactive (ext_memory_nactive),
		.ext_memory_address (ext_memory_address),
		.sample             (sample),
		.sample_valid       (sample_valid)
	);

	always #20 clk = ~clk;

	`include "tb_scc_wave_cases.svh"

	task automatic add_case(input string name, input op_t op, input logic [14:0] addr,
	                        input logic [7:0] data, input int expected);
		case_t c;
		c.name = name;
		c.op = op;
		c.addr = addr;
		c.data = data;
		c.expected = expected;
		cases.push_back(c);
	endtask

	// ------------------------------------------------------------------------
	// Reference model of the address map and the mixing rule
	// ------------------------------------------------------------------------

	// Regions 10, 11, 00, 01 of address[14:13]
	function automatic int region_of(input logic [14:0] a);
		case (a[14:13])
			2'b10: return 0;
			2'b11: return 1;
			2'b00: return 2;
			default: return 3;
		endcase
	endfunction

	function automatic bit scc_open(input logic [14:0] a);
		return (bank_model[2] == 8'h3F) && !scci_model && (a[14:8] == 7'h18);
	endfunction

	function automatic bit scci_open(input logic [14:0] a);
		return bank_model[3][7] && scci_model && (a[14:11] == 4'b0111);
	endfunction

	// Channel register number, or -1 outside the register area
	function automatic int chan_reg_of(input logic [14:0] a);
		if (scc_open(a) && (a[7:4] == 4'h8)) begin
			return a[3:0];
		end
		if (scci_open(a) && (a[7:4] == 4'hA)) begin
			return a[3:0];
		end
		return -1;
	endfunction

	function automatic bit table_hit(input logic [14:0] a, input bit is_write,
	                                 output int id, output int idx);
		idx = a[4:0];
		id = 0;
		if (scc_open(a) && !a[7]) begin
			id = a[6:5];
			return 1'b1;
		end
		// Read-only copy of table D
		if (scc_open(a) && (a[7:5] == 3'b101) && !is_write) begin
			id = 3;
			return 1'b1;
		end
		if (scci_open(a) && (a[10:8] == 3'b000) && (a[7:0] < 8'hA0)) begin
			id = a[7:5];
			return 1'b1;
		end
		return 1'b0;
	endfunction

	function automatic int model_read(input logic [14:0] a);
		int id;
		int idx;
		if (table_hit(a, 1'b0, id, idx)) begin
			return wave_model[id][idx];
		end
		return 0;
	endfunction

	task automatic model_write(input logic [14:0] a, input logic [7:0] d);
		int id;
		int idx;
		int reg_num;
		int region;
		region = region_of(a);
		reg_num = chan_reg_of(a);
		if (table_hit(a, 1'b1, id, idx)) begin
			wave_model[id][idx] = d;
		end else if ((reg_num >= 10) && (reg_num < 15)) begin
			vol_model[reg_num - 10] = d[3:0];
		end else if (reg_num == 15) begin
			mask_model = d[4:0];
		end
		if (a[12] && !a[11] && !ram_model[region]) begin
			bank_model[region] = d;
		end
		// Mode register at 3FFE and 3FFF
		if (a[14:1] == 14'h1FFF) begin
			scci_model = d[5];
			for (int i = 0; i < 4; i++) begin
				ram_model[i] = d[4] || ((i < 3) && d[i]);
			end
		end
	endtask

	function automatic int expected_sample();
		int  sum;
		int  p;
		byte w;
		sum = 0;
		for (int ch = 0; ch < `SCC_CHANNELS; ch++) begin
			if (mask_model[ch]) begin
				// Wave reset holds every pointer at index 0
				w = wave_model[ch][0];
				p = w * int'(vol_model[ch]);
				sum += p >>> 4;
			end
		end
		return sum;
	endfunction

	// ------------------------------------------------------------------------
	// Bus tasks, each starts and ends 2 ns after a rising edge
	// ------------------------------------------------------------------------
	task automatic idle_cycle();
		bus = '0;
		@(posedge clk);
		#2;
	endtask

	task automatic bus_write(input logic [14:0] a, input logic [7:0] d);
		bus = '0;
		bus.wrreq = 1'b1;
		bus.wr_active = 1'b1;
		bus.address = a;
		bus.wrdata = d;
		@(posedge clk);
		#2;
		idle_cycle();
	endtask

	task automatic bus_read(input logic [14:0] a, output bit got, output logic [7:0] data,
	                        output int latency);
		bus = '0;
		bus.rdreq = 1'b1;
		bus.rd_active = 1'b1;
		bus.address = a;
		got = 1'b0;
		data = '0;
		latency = 0;
		while (!got && (latency < READ_TIMEOUT)) begin
			@(posedge clk);
			#1;
			latency++;
			if (rddata_en) begin
				got = 1'b1;
				data = rddata;
			end
			#1;
			bus.rdreq = 1'b0;
		end
		idle_cycle();
	endtask

	task automatic wait_sample(output bit got, output int value);
		int waited;
		got = 1'b0;
		value = 0;
		waited = 0;
		while (!got && (waited < SAMPLE_TIMEOUT)) begin
			@(posedge clk);
			#1;
			waited++;
			if (sample_valid) begin
				got = 1'b1;
				value = sample;
			end
			#1;
		end
	endtask

	// ------------------------------------------------------------------------
	// One case of the table
	// ------------------------------------------------------------------------
	task automatic run_case(input case_t c);
		bit         got;
		logic [7:0] data;
		int         latency;
		int         expected;
		int         actual;
		int         errors_before;
		errors_before = check_errors;
		case (c.op)
			OP_WRITE, OP_FILL: begin
				data = (c.op == OP_FILL) ? 8'($urandom) : c.data;
				if (enable) begin
					model_write(c.addr, data);
				end
				bus_write(c.addr, data);
			end
			OP_READ: begin
				expected = model_read(c.addr);
				bus_read(c.addr, got, data, latency);
				assert (got) else begin
					$display("%s: no read data before the timeout", c.name);
					check_errors++;
				end
				if (got) begin
					assert (latency == READ_LATENCY) else begin
						$display("%s: read data came %0d cycles after the request", c.name,
						         latency);
						check_errors++;
					end
					assert (data == expected) else begin
						$display("mismatch %s expected %02h actual %02h", c.name, expected, data);
						check_errors++;
					end
				end
			end
			OP_NO_READ: begin
				bus_read(c.addr, got, data, latency);
				assert (!got) else begin
					$display("%s: read data came back from a closed window", c.name);
					check_errors++;
				end
			end
			OP_MAP: begin
				bus = '0;
				bus.address = c.addr;
				#1;
				actual = ext_memory_address;
				assert (actual == c.expected) else begin
					$display("mismatch %s expected %02h actual %02h", c.name, c.expected, actual);
					check_errors++;
				end
				idle_cycle();
			end
			OP_NACTIVE: begin
				actual = ext_memory_nactive;
				assert (actual == c.expected) else begin
					$display("mismatch %s expected %0d actual %0d", c.name, c.expected, actual);
					check_errors++;
				end
			end
			OP_SAMPLE: begin
				expected = expected_sample();
				// The first two rounds may still mix older settings
				for (int n = 0; n < 3; n++) begin
					wait_sample(got, actual);
					assert (got) else begin
						$display("%s: no sample before the timeout", c.name);
						check_errors++;
					end
				end
				assert (!got || (actual == expected)) else begin
					$display("mismatch %s expected %0d actual %0d", c.name, expected, actual);
					check_errors++;
				end
			end
			OP_ENABLE: begin
				enable = c.data[0];
				@(posedge clk);
				#2;
			end
			default: begin
				$display("%s: unknown operation in the case table", c.name);
				check_errors++;
			end
		endcase
		if (check_errors == errors_before) begin
			tests_ok++;
			$display("[%0d] %s ok", tests_ok + tests_bad, c.name);
		end else begin
			tests_bad++;
			$display("[%0d] %s error", tests_ok + tests_bad, c.name);
		end
	endtask

	initial begin
		clk = 1'b0;
		nreset = 1'b0;
		enable = 1'b1;
		bus = '0;
		check_errors = 0;
		tests_ok = 0;
		tests_bad = 0;
		void'($urandom(32'ha7e0));
		bank_model[0] = 8'd0;
		bank_model[1] = 8'd1;
		bank_model[2] = 8'd2;
		bank_model[3] = 8'd3;
		ram_model = '0;
		scci_model = 1'b0;
		mask_model = '0;
		for (int ch = 0; ch < `SCC_CHANNELS; ch++) begin
			vol_model[ch] = '0;
			for (int i = 0; i < `SCC_WAVE_DEPTH; i++) begin
				wave_model[ch][i] = '0;
			end
		end
		load_cases();
		repeat (2) @(posedge clk);
		#2;
		nreset = 1'b1;
		for (int i = 0; i < cases.size(); i++) begin
			run_case(cases[i]);
		end
		$display("tests: %0d ok, %0d with errors", tests_ok, tests_bad);
		if ((tests_bad == 0) && (check_errors == 0)) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/scc_wave.sv ====
// Wave-table sound cartridge core, top level
// Host bus in, bank address and select out, one mixed sample per five enabled clocks
// No back-pressure on the host side, reads must be spaced four cycles apart

`timescale 1ns/1ns
`default_nettype none

`include "scc_defines.svh"

module scc_wave (
	input  logic                              clk,
	input  logic                              nreset,
	input  logic                              enable,
	input  scc_pkg::scc_bus_t                 bus,
	output logic [7:0]                        rddata,
	output logic                              rddata_en,
	output logic                              ext_memory_nactive,
	output logic [7:0]                        ext_memory_address,
	output logic signed [`SCC_SAMPLE_W-1:0]   sample,
	output logic                              sample_valid
);
	import scc_pkg::*;

	scc_wave_req_t              wave_req;
	logic [7:0]                 sram_q;
	logic                       sram_q_en;
	scc_chan_t                  chan [`SCC_CHANNELS];
	scc_volume_t                volume_values [`SCC_CHANNELS];
	logic [`SCC_CHANNELS-1:0]   clear_counter;
	logic                       wave_reset;
	scc_chan_t                  chan_now;
	scc_volume_t                volume_now;
	scc_slot_t                  slot;
	logic [4:0]                 play_index;
	logic [7:0]                 play_q;

	scc_register u_register (
		.clk                (clk),
		.nreset             (nreset),
		.enable             (enable),
		.bus                (bus),
		.rddata             (rddata),
		.rddata_en          (rddata_en),
		.ext_memory_nactive (ext_memory_nactive),
		.ext_memory_address (ext_memory_address),
		.wave_req           (wave_req),
		.sram_q             (sram_q),
		.sram_q_en          (sram_q_en),
		.chan               (chan),
		.clear_counter      (clear_counter),
		.wave_reset         (wave_reset),
		.scci_enable        ()
	);

	scc_selector #(.payload_t(scc_chan_t)) u_chan_selector (
		.clk    (clk),
		.slot   (slot),
		.values (chan),
		.result (chan_now)
	);

	// By the time a slot's volume is picked the issued slot has moved on by one,
	// so entry i carries the volume of the slot before it
	for (genvar i = 0; i < `SCC_CHANNELS; i++) begin : g_volume
		assign volume_values[i] = chan[(i + `SCC_CHANNELS - 1) % `SCC_CHANNELS].volume;
	end

	scc_selector #(.payload_t(scc_volume_t)) u_volume_selector (
		.clk    (clk),
		.slot   (slot),
		.values (volume_values),
		.result (volume_now)
	);

	scc_wave_memory u_wave_memory (
		.clk        (clk),
		.nreset     (nreset),
		.wave_req   (wave_req),
		.sram_q     (sram_q),
		.sram_q_en  (sram_q_en),
		.play_slot  (slot),
		.play_index (play_index),
		.play_q     (play_q)
	);

	scc_tone_generator u_tone_generator (
		.clk           (clk),
		.nreset        (nreset),
		.enable        (enable),
		.chan_now      (chan_now),
		.volume_now    (volume_now),
		.clear_counter (clear_counter),
		.wave_reset    (wave_reset),
		.slot          (slot),
		.play_index    (play_index),
		.play_q        (play_q),
		.sample        (sample),
		.sample_valid  (sample_valid)
	);

endmodule

`default_nettype wire

// ==== design/scc_tone_generator.sv ====
// Time-multiplexed tone generator for five channels
// One slot is issued per enabled clock, 0 to 4, and a sample is published per round
// Each channel's counter and pointer move once per round, so one count lasts five clocks
// While enable is low the issued slot falls back to the stage-1 slot to keep the
// ungated selectors and playback read aligned with the held pipeline

`timescale 1ns/1ns
`default_nettype none

`include "scc_defines.svh"

module scc_tone_generator (
	input  logic                              clk,
	input  logic                              nreset,
	input  logic                              enable,
	input  scc_pkg::scc_chan_t                chan_now,
	input  scc_pkg::scc_volume_t              volume_now,
	input  logic [`SCC_CHANNELS-1:0]          clear_counter,
	input  logic                              wave_reset,
	output scc_pkg::scc_slot_t                slot,
	output logic [4:0]                        play_index,
	input  logic [7:0]                        play_q,
	output logic signed [`SCC_SAMPLE_W-1:0]   sample,
	output logic                              sample_valid
);
	import scc_pkg::*;

	localparam int SAMPLE_W = `SCC_SAMPLE_W;
	localparam scc_slot_t LAST_SLOT = scc_slot_t'(`SCC_CHANNELS - 1);

	scc_slot_t                    issue_slot;
	scc_slot_t                    slot_d1;
	scc_slot_t                    slot_d2;
	logic                         valid_d1;
	logic                         valid_d2;
	logic                         enable_d2;
	scc_freq_t                    counter [`SCC_CHANNELS];
	logic [4:0]                   pointer [`SCC_CHANNELS];
	logic [`SCC_CHANNELS-1:0]     clear_pending;
	logic signed [7:0]            wave_d2;
	logic signed [12:0]           product;
	logic signed [SAMPLE_W-1:0]   scaled;
	logic signed [SAMPLE_W-1:0]   acc;

	assign slot       = enable ? issue_slot : slot_d1;
	assign play_index = wave_reset ? 5'd0 : pointer[slot];

	// --------------------------------------------------------------------------
	// Slot pipeline
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			issue_slot <= '0;
			slot_d1    <= LAST_SLOT;
			slot_d2    <= LAST_SLOT - 3'd1;
			valid_d1   <= 1'b0;
			valid_d2   <= 1'b0;
			enable_d2  <= 1'b0;
		end else if (enable) begin
			issue_slot <= (issue_slot == LAST_SLOT) ? 3'd0 : issue_slot + 3'd1;
			slot_d1    <= issue_slot;
			slot_d2    <= slot_d1;
			valid_d1   <= 1'b1;
			valid_d2   <= valid_d1;
			enable_d2  <= valid_d1 && chan_now.enable;
		end
	end

	// Counters and pointers, updated when the slot's settings arrive
	always_ff @(posedge clk) begin
		if (!nreset) begin
			for (int i = 0; i < `SCC_CHANNELS; i++) begin
				counter[i] <= '0;
				pointer[i] <= '0;
			end
			clear_pending <= '0;
		end else if (enable) begin
			clear_pending <= clear_pending | clear_counter;
			if (valid_d1) begin
				if (clear_pending[slot_d1] || clear_counter[slot_d1]) begin
					counter[slot_d1]       <= chan_now.freq;
					clear_pending[slot_d1] <= 1'b0;
				end else if (counter[slot_d1] == '0) begin
					counter[slot_d1] <= chan_now.freq;
					pointer[slot_d1] <= pointer[slot_d1] + 5'd1;
				end else begin
					counter[slot_d1] <= counter[slot_d1] - 12'd1;
				end
			end
			if (wave_reset) begin
				for (int i = 0; i < `SCC_CHANNELS; i++) begin
					pointer[i] <= '0;
				end
			end
		end
	end

	// --------------------------------------------------------------------------
	// Volume scaling and mixing
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (enable) begin
			wave_d2 <= play_q;
		end
	end

	assign product = wave_d2 * $signed({1'b0, volume_now});
	assign scaled  = enable_d2 ? SAMPLE_W'(product >>> 4) : '0;

	always_ff @(posedge clk) begin
		if (!nreset) begin
			acc          <= '0;
			sample       <= '0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= enable && valid_d2 && (slot_d2 == LAST_SLOT);
			if (enable && valid_d2) begin
				// Slot 0 starts a new round
				acc <= (slot_d2 == 3'd0) ? scaled : acc + scaled;
				if (slot_d2 == LAST_SLOT) begin
					sample <= acc + scaled;
				end
			end
		end
	end

	// At most one channel restarts per host write
	a_clear_one_channel: assert property (@(posedge clk) disable iff (!nreset)
		$onehot0(clear_counter));

endmodule

`default_nettype wire

// ==== design/scc_wave_memory.sv ====
// Five 32-byte wave tables
// Host port: write on we, read data one cycle after oe with sram_q_en
// Playback port is a separate registered read, always active
// Table ids above 4 are ignored on write

`timescale 1ns/1ns
`default_nettype none

`include "scc_defines.svh"

module scc_wave_memory (
	input  logic                    clk,
	input  logic                    nreset,
	input  scc_pkg::scc_wave_req_t  wave_req,
	output logic [7:0]              sram_q,
	output logic                    sram_q_en,
	input  scc_pkg::scc_slot_t      play_slot,
	input  logic [4:0]              play_index,
	output logic [7:0]              play_q
);

	logic [7:0] table_mem [`SCC_CHANNELS][`SCC_WAVE_DEPTH];

	// Host port
	always_ff @(posedge clk) begin
		if (wave_req.we && (wave_req.id < `SCC_CHANNELS)) begin
			table_mem[wave_req.id][wave_req.index] <= wave_req.data;
		end
		if (wave_req.oe) begin
			sram_q <= table_mem[wave_req.id][wave_req.index];
		end
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			sram_q_en <= 1'b0;
		end else begin
			sram_q_en <= wave_req.oe;
		end
	end

	// Playback port
	// Reads every clock so the tone generator can hold its slot while disabled
	always_ff @(posedge clk) begin
		play_q <= table_mem[play_slot][play_index];
	end

endmodule

`default_nettype wire

// ==== design/scc_selector.sv ====
// Registered pick of one channel's value by slot
// Slots above the channel count give an all-zero payload
// No reset, the result is valid one clock after the slot

`timescale 1ns/1ns
`default_nettype none

`include "scc_defines.svh"

module scc_selector #(
	parameter type payload_t = logic
) (
	input  logic                clk,
	input  scc_pkg::scc_slot_t  slot,
	input  payload_t            values [`SCC_CHANNELS],
	output payload_t            result
);

	// Same latency as the wave table playback read
	always_ff @(posedge clk) begin
		if (slot < `SCC_CHANNELS) begin
			result <= values[slot];
		end else begin
			result <= payload_t'(0);
		end
	end

endmodule

`default_nettype wire

// ==== design/scc_register.sv ====
// Host side of the cartridge core: mapper banks, mode register and SCC/SCCI windows
// Only the bank address and select of the cartridge memory are driven here
// Reads take three cycles from rdreq to rddata_en and must be spaced four apart
// Strobes to the wave tables drop while enable is low

`timescale 1ns/1ns
`default_nettype none

`include "scc_defines.svh"

module scc_register (
	input  logic                        clk,
	input  logic                        nreset,
	input  logic                        enable,
	input  scc_pkg::scc_bus_t           bus,
	output logic [7:0]                  rddata,
	output logic                        rddata_en,
	output logic                        ext_memory_nactive,
	output logic [7:0]                  ext_memory_address,
	output scc_pkg::scc_wave_req_t      wave_req,
	input  logic [7:0]                  sram_q,
	input  logic                        sram_q_en,
	output scc_pkg::scc_chan_t          chan [`SCC_CHANNELS],
	output logic [`SCC_CHANNELS-1:0]    clear_counter,
	output logic                        wave_reset,
	output logic                        scci_enable
);
	import scc_pkg::*;

	logic [7:0]  bank [4];
	logic [3:0]  ram_mode;
	logic [1:0]  bank_sel;
	logic        ram_hit;
	logic        mode_sel;
	logic        scc_en;
	logic        scci_en;
	logic        chan_sel;
	logic        wave_sel;
	logic        table_sel;
	logic        read_only_sel;
	logic        nactive_next;
	scc_slot_t   freq_chan;
	scc_slot_t   vol_chan;

	// --------------------------------------------------------------------------
	// Address decoding
	// --------------------------------------------------------------------------

	// Regions 10, 11, 00, 01 map to banks 0 to 3
	assign bank_sel           = {~bus.address[14], bus.address[13]};
	assign ext_memory_address = bank[bank_sel];
	assign ram_hit            = ram_mode[bank_sel];

	// 3FFE and 3FFF
	assign mode_sel = (bank_sel == 2'd3) && (bus.address[12:1] == 12'hFFF);

	assign scc_en  = (bank[2] == 8'h3F) && (bank_sel == 2'd2) && !scci_enable &&
	                 (bus.address[12:8] == 5'b11000);
	assign scci_en = bank[3][7] && (bank_sel == 2'd3) && scci_enable &&
	                 (bus.address[12:11] == 2'b11);

	// 1880-188F or 38A0-38AF
	assign chan_sel = (scc_en && (bus.address[7:4] == 4'h8)) ||
	                  (scci_en && (bus.address[7:4] == 4'hA));
	// 18E0-18FF or 38C0-38DF
	assign wave_sel = (scc_en && (bus.address[7:5] == 3'b111)) ||
	                  (scci_en && (bus.address[7:5] == 3'b110));

	// Writable tables, 1800-187F or 3800-389F
	assign table_sel = (scc_en && !bus.address[7]) ||
	                   (scci_en && (bus.address[10:8] == 3'b000) &&
	                    (!bus.address[7] || (bus.address[7:5] == 3'b100)));
	assign read_only_sel = scc_en && (bus.address[7:5] == 3'b101);

	// Register order is freq low/high A to E, volume A to E, enable mask
	assign freq_chan = bus.address[3:1];
	assign vol_chan  = 3'(bus.address[3:0] - 4'd10);

	// --------------------------------------------------------------------------
	// Bank and mode registers
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			bank[0] <= 8'd0;
			bank[1] <= 8'd1;
			bank[2] <= 8'd2;
			bank[3] <= 8'd3;
		end else if (enable && bus.wrreq && bus.address[12] && !bus.address[11] && !ram_hit) begin
			bank[bank_sel] <= bus.wrdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			scci_enable <= 1'b0;
			ram_mode    <= '0;
		end else if (enable && bus.wrreq && mode_sel) begin
			scci_enable <= bus.wrdata[5];
			// Bit 4 puts every bank in RAM mode
			ram_mode    <= {bus.wrdata[4], bus.wrdata[4] | bus.wrdata[2],
			                bus.wrdata[4] | bus.wrdata[1], bus.wrdata[4] | bus.wrdata[0]};
		end
	end

	// Cartridge memory select
	always_comb begin
		nactive_next = ext_memory_nactive;
		if (mode_sel && !bus.rd_active) begin
			nactive_next = 1'b1;
		end else if (scc_en) begin
			nactive_next = !(bus.address[7] && bus.rd_active);
		end else if (scci_en) begin
			nactive_next = !(bus.address[7] && (bus.address[7:5] != 3'b100) && bus.rdreq);
		end else if (bus.rd_active || ram_hit) begin
			nactive_next = 1'b0;
		end else if (!bus.wr_active) begin
			nactive_next = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			ext_memory_nactive <= 1'b1;
		end else if (enable) begin
			ext_memory_nactive <= nactive_next;
		end
	end

	// --------------------------------------------------------------------------
	// Channel registers
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			for (int i = 0; i < `SCC_CHANNELS; i++) begin
				chan[i] <= '0;
			end
			wave_reset <= 1'b0;
		end else if (enable && bus.wrreq) begin
			if (chan_sel) begin
				if (bus.address[3:0] < 4'd10) begin
					if (bus.address[0]) begin
						chan[freq_chan].freq[11:8] <= bus.wrdata[3:0];
					end else begin
						chan[freq_chan].freq[7:0] <= bus.wrdata;
					end
				end else if (bus.address[3:0] != 4'hF) begin
					chan[vol_chan].volume <= bus.wrdata[3:0];
				end else begin
					for (int i = 0; i < `SCC_CHANNELS; i++) begin
						chan[i].enable <= bus.wrdata[i];
					end
				end
			end
			if (wave_sel) begin
				wave_reset <= bus.wrdata[5];
			end
		end
	end

	// Any frequency byte write restarts that channel's counter
	always_comb begin
		clear_counter = '0;
		if (bus.wrreq && chan_sel && (bus.address[3:0] < 4'd10)) begin
			clear_counter[freq_chan] = 1'b1;
		end
	end

	// --------------------------------------------------------------------------
	// Wave table port and read return
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			wave_req.oe <= 1'b0;
			wave_req.we <= 1'b0;
		end else if (enable && (table_sel || read_only_sel)) begin
			if (read_only_sel) begin
				wave_req.id <= 3'd3;
			end else if (scc_en) begin
				wave_req.id <= {1'b0, bus.address[6:5]};
			end else begin
				wave_req.id <= bus.address[7:5];
			end
			wave_req.index <= bus.address[4:0];
			wave_req.data  <= bus.wrdata;
			wave_req.oe    <= bus.rdreq;
			wave_req.we    <= bus.wrreq && table_sel;
		end else begin
			wave_req.oe <= 1'b0;
			wave_req.we <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (sram_q_en) begin
			rddata <= sram_q;
		end
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			rddata_en <= 1'b0;
		end else begin
			rddata_en <= sram_q_en;
		end
	end

	a_wave_oe_we_exclusive: assert property (@(posedge clk) disable iff (!nreset)
		!(wave_req.oe && wave_req.we));

	// A table access follows a table address on the bus one cycle earlier
	a_wave_access_in_window: assert property (@(posedge clk) disable iff (!nreset)
		(wave_req.oe || wave_req.we) |->
		$past(((bus.address[14:8] == 7'h18) && (bus.address[7:5] != 3'b100) &&
		       (bus.address[7:6] != 2'b11)) ||
		      ((bus.address[14:8] == 7'h38) && (bus.address[7:0] < 8'hA0))));

endmodule

`default_nettype wire

// ==== design/scc_pkg.sv ====
// Shared types of the wave-table core
// Struct layouts are fixed, the testbench packs the bus struct directly

`default_nettype none

`include "scc_defines.svh"

package scc_pkg;

	// One host bus cycle, 27 bits
	typedef struct packed {
		logic                     wrreq;
		logic                     rdreq;
		logic                     wr_active;
		logic                     rd_active;
		logic [`SCC_ADDR_W-1:0]   address;
		logic [`SCC_DATA_W-1:0]   wrdata;
	} scc_bus_t;

	// Host command to the wave tables, 18 bits
	typedef struct packed {
		logic [2:0]                          id;
		logic [$clog2(`SCC_WAVE_DEPTH)-1:0]  index;
		logic [`SCC_DATA_W-1:0]              data;
		logic                                oe;
		logic                                we;
	} scc_wave_req_t;

	typedef logic [11:0] scc_freq_t;
	typedef logic [3:0]  scc_volume_t;

	// Channel slot, A=0 to E=4
	typedef logic [2:0]  scc_slot_t;

	// Playback settings of one channel, 17 bits
	typedef struct packed {
		scc_freq_t   freq;
		scc_volume_t volume;
		logic        enable;
	} scc_chan_t;

endpackage

`default_nettype wire

// ==== design/scc_defines.svh ====
// Fixed sizes of the wave-table core
// The register map and address decoding assume these exact values,
// so they are not meant to be changed on their own

`ifndef SCC_DEFINES_SVH
`define SCC_DEFINES_SVH

// Tone channels A to E
`define SCC_CHANNELS 5

// Samples in one wave table, one byte each
`define SCC_WAVE_DEPTH 32

// Mixed output sample, signed
// Five channels of at most +/-128 after volume scaling fit in 11 bits
`define SCC_SAMPLE_W 11

// Host bus widths
`define SCC_ADDR_W 15
`define SCC_DATA_W 8

`endif
